//--- hdl/tetris_cfg_pkg.sv
`default_nettype none

package tetris_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // board geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int board_rows = 20;
    localparam int board_cols = 10;

    // row 0 is the top, column 0 the left wall
    typedef logic [4:0] row_t;
    typedef logic [3:0] col_t;
    typedef logic [board_rows-1:0][board_cols-1:0] board_t;
    typedef logic [3:0][3:0] pattern_t;
    typedef logic [2:0] piece_id_t;

    localparam row_t spawn_row = 5'd0;
    localparam col_t spawn_col = 4'd3;

    ////////////////////////////////////////////////////////////////////////////
    // tetromino shapes, pattern[row][col] with col 0 at the left
    ////////////////////////////////////////////////////////////////////////////
    localparam piece_id_t piece_i = 3'd0;
    localparam piece_id_t piece_o = 3'd1;
    localparam piece_id_t piece_t = 3'd2;
    localparam piece_id_t piece_s = 3'd3;
    localparam piece_id_t piece_z = 3'd4;
    localparam piece_id_t piece_j = 3'd5;
    localparam piece_id_t piece_l = 3'd6;

    function automatic pattern_t piece_pattern(piece_id_t id);
        pattern_t p;
        p = '0;
        case (id)
            piece_i: p[0] = 4'b1111;
            piece_o: begin
                p[0] = 4'b0011;
                p[1] = 4'b0011;
            end
            piece_t: begin
                p[0] = 4'b0111;
                p[1] = 4'b0010;
            end
            piece_s: begin
                p[0] = 4'b0110;
                p[1] = 4'b0011;
            end
            piece_z: begin
                p[0] = 4'b0011;
                p[1] = 4'b0110;
            end
            piece_j: begin
                p[0] = 4'b0001;
                p[1] = 4'b0111;
            end
            piece_l: begin
                p[0] = 4'b0100;
                p[1] = 4'b0111;
            end
            // id 7 has no shape
            default: p = '0;
        endcase
        return p;
    endfunction

endpackage

`default_nettype wire

//--- hdl/tetris_io_pkg.sv
`default_nettype none

package tetris_io_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // player side
    ////////////////////////////////////////////////////////////////////////////

    // one-cycle strobes, only honoured while in play
    typedef struct packed {
        logic move_left;
        logic move_right;
        logic hard_drop;
        logic tick;
    } cmd_t;

    ////////////////////////////////////////////////////////////////////////////
    // game side
    ////////////////////////////////////////////////////////////////////////////

    // in_play and game_over are levels, piece_locked pulses once per lock
    typedef struct packed {
        logic in_play;
        logic piece_locked;
        logic game_over;
    } status_t;

endpackage

`default_nettype wire

//--- hdl/collision.sv
`timescale 1ns/1ps
`default_nettype none

module collision (
    input  tetris_cfg_pkg::row_t     blockY,
    input  tetris_cfg_pkg::col_t     blockX,
    input  tetris_cfg_pkg::pattern_t current_block_pattern,
    input  tetris_cfg_pkg::board_t   stored_array,
    output logic                     collision_bottom,
    output logic                     collision_left,
    output logic                     collision_right,
    output tetris_cfg_pkg::board_t   falling_block_display
);

    ////////////////////////////////////////////////////////////////////////////
    // place the 4x4 mask on the board and look at the neighbour cells
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        tetris_cfg_pkg::row_t cell_row;
        tetris_cfg_pkg::col_t cell_col;
        logic                 on_board;

        collision_bottom      = 1'b0;
        collision_left        = 1'b0;
        collision_right       = 1'b0;
        falling_block_display = '0;
        cell_row              = '0;
        cell_col              = '0;
        on_board              = 1'b0;

        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                // absolute cell, no wrap since 19+3 and 9+3 still fit
                cell_row = blockY + tetris_cfg_pkg::row_t'(r);
                cell_col = blockX + tetris_cfg_pkg::col_t'(c);
                on_board = (cell_row < tetris_cfg_pkg::row_t'(tetris_cfg_pkg::board_rows)) &&
                           (cell_col < tetris_cfg_pkg::col_t'(tetris_cfg_pkg::board_cols));

                if (current_block_pattern[r][c] && on_board) begin
                    falling_block_display[cell_row][cell_col] = 1'b1;

                    // floor or a stored cell right below
                    if (cell_row == tetris_cfg_pkg::row_t'(tetris_cfg_pkg::board_rows - 1)) begin
                        collision_bottom = 1'b1;
                    end else if (stored_array[cell_row + 5'd1][cell_col]) begin
                        collision_bottom = 1'b1;
                    end

                    // left wall or stack
                    if (cell_col == 4'd0) begin
                        collision_left = 1'b1;
                    end else if (stored_array[cell_row][cell_col - 4'd1]) begin
                        collision_left = 1'b1;
                    end

                    // right wall or stack
                    if (cell_col == tetris_cfg_pkg::col_t'(tetris_cfg_pkg::board_cols - 1)) begin
                        collision_right = 1'b1;
                    end else if (stored_array[cell_row][cell_col + 4'd1]) begin
                        collision_right = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/playfield.sv
`timescale 1ns/1ps
`default_nettype none

module playfield (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lock_en,
    input  logic                   clear_en,
    input  tetris_cfg_pkg::board_t falling,
    output tetris_cfg_pkg::board_t stored,
    output logic                   full_any,
    output logic                   overlap
);

    logic [tetris_cfg_pkg::board_rows-1:0] full_row;
    tetris_cfg_pkg::row_t                  clear_row;
    tetris_cfg_pkg::board_t                shifted;

    ////////////////////////////////////////////////////////////////////////////
    // row status
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int r = 0; r < tetris_cfg_pkg::board_rows; r++) begin
            full_row[r] = &stored[r];
        end
    end

    assign full_any = |full_row;

    // a fresh piece sitting on stored cells means the stack reached the top
    assign overlap = |(stored & falling);

    // lowest full row, the later (higher) index wins
    always_comb begin
        clear_row = '0;
        for (int r = 0; r < tetris_cfg_pkg::board_rows; r++) begin
            if (full_row[r]) begin
                clear_row = tetris_cfg_pkg::row_t'(r);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // board with clear_row removed
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        shifted = stored;
        for (int r = 1; r < tetris_cfg_pkg::board_rows; r++) begin
            // rows at and above the cleared one drop by one
            if (tetris_cfg_pkg::row_t'(r) <= clear_row) begin
                shifted[r] = stored[r-1];
            end
        end
        // top row always refills empty
        shifted[0] = '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stored board
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stored <= '0;
        end else if (lock_en) begin
            stored <= stored | falling;
        end else if (clear_en) begin
            stored <= shifted;
        end
    end

endmodule

`default_nettype wire

//--- hdl/game_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module game_ctrl #(
    parameter int lines_w = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  tetris_cfg_pkg::piece_id_t piece_sel,
    input  tetris_io_pkg::cmd_t       cmd,
    input  logic                      collision_bottom,
    input  logic                      collision_left,
    input  logic                      collision_right,
    input  logic                      full_any,
    input  logic                      overlap,
    output tetris_cfg_pkg::row_t      block_row,
    output tetris_cfg_pkg::col_t      block_col,
    output tetris_cfg_pkg::pattern_t  pattern,
    output logic                      lock_en,
    output logic                      clear_en,
    output logic [lines_w-1:0]        lines,
    output tetris_io_pkg::status_t    status
);

    typedef enum logic [2:0] {
        idle,
        spawn,
        check,
        play,
        drop,
        lock,
        clear,
        over
    } state_t;

    state_t state;

    ////////////////////////////////////////////////////////////////////////////
    // state, piece position and line count
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            block_row <= '0;
            block_col <= '0;
            pattern   <= '0;
            lines     <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= spawn;
                    end
                end
                spawn: begin
                    block_row <= tetris_cfg_pkg::spawn_row;
                    block_col <= tetris_cfg_pkg::spawn_col;
                    pattern   <= tetris_cfg_pkg::piece_pattern(piece_sel);
                    state     <= check;
                end
                check: begin
                    state <= overlap ? over : play;
                end
                play: begin
                    // one command per cycle, drop first
                    if (cmd.hard_drop) begin
                        state <= drop;
                    end else if (cmd.tick) begin
                        if (collision_bottom) begin
                            state <= lock;
                        end else begin
                            block_row <= block_row + 5'd1;
                        end
                    end else if (cmd.move_left) begin
                        if (!collision_left) begin
                            block_col <= block_col - 4'd1;
                        end
                    end else if (cmd.move_right) begin
                        if (!collision_right) begin
                            block_col <= block_col + 4'd1;
                        end
                    end
                end
                drop: begin
                    if (collision_bottom) begin
                        state <= lock;
                    end else begin
                        block_row <= block_row + 5'd1;
                    end
                end
                lock: begin
                    // piece now lives in the stored board
                    pattern <= '0;
                    state   <= clear;
                end
                clear: begin
                    if (full_any) begin
                        lines <= lines + 1'b1;
                    end else begin
                        state <= spawn;
                    end
                end
                // held until reset
                over: state <= over;
                default: state <= idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // playfield strobes and status decode
    ////////////////////////////////////////////////////////////////////////////
    assign lock_en  = (state == lock);
    assign clear_en = (state == clear) && full_any;

    always_comb begin
        status              = '0;
        status.in_play      = (state == play);
        status.piece_locked = (state == lock);
        status.game_over    = (state == over);
    end

endmodule

`default_nettype wire

//--- hdl/tetris_core.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_core #(
    parameter int lines_w = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  tetris_cfg_pkg::piece_id_t piece_sel,
    input  tetris_io_pkg::cmd_t       cmd,
    output tetris_cfg_pkg::board_t    display,
    output logic [lines_w-1:0]        lines,
    output tetris_io_pkg::status_t    status
);

    tetris_cfg_pkg::row_t     block_row;
    tetris_cfg_pkg::col_t     block_col;
    tetris_cfg_pkg::pattern_t pattern;
    tetris_cfg_pkg::board_t   falling_block_display;
    tetris_cfg_pkg::board_t   stored;
    logic                     collision_bottom;
    logic                     collision_left;
    logic                     collision_right;
    logic                     lock_en;
    logic                     clear_en;
    logic                     full_any;
    logic                     overlap;

    game_ctrl #(
        .lines_w (lines_w)
    ) i_game_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .piece_sel        (piece_sel),
        .cmd              (cmd),
        .collision_bottom (collision_bottom),
        .collision_left   (collision_left),
        .collision_right  (collision_right),
        .full_any         (full_any),
        .overlap          (overlap),
        .block_row        (block_row),
        .block_col        (block_col),
        .pattern          (pattern),
        .lock_en          (lock_en),
        .clear_en         (clear_en),
        .lines            (lines),
        .status           (status)
    );

    collision i_collision (
        .blockY                (block_row),
        .blockX                (block_col),
        .current_block_pattern (pattern),
        .stored_array          (stored),
        .collision_bottom      (collision_bottom),
        .collision_left        (collision_left),
        .collision_right       (collision_right),
        .falling_block_display (falling_block_display)
    );

    playfield i_playfield (
        .clk      (clk),
        .rst_n    (rst_n),
        .lock_en  (lock_en),
        .clear_en (clear_en),
        .falling  (falling_block_display),
        .stored   (stored),
        .full_any (full_any),
        .overlap  (overlap)
    );

    // stack plus the piece still falling
    assign display = stored | falling_block_display;

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int lines_w = 8
) (
    input wire logic                   clk,
    input wire tetris_cfg_pkg::board_t display,
    input wire logic [lines_w-1:0]     lines,
    input wire tetris_io_pkg::status_t status
);

    int pass_count = 0;
    int fail_count = 0;
    int lock_count = 0;

    // every lock pulse of the run
    always @(posedge clk) begin
        if (status.piece_locked) begin
            lock_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // settle point compare
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_state(int test, string name, tetris_cfg_pkg::board_t exp_board,
                               int exp_lines, logic exp_go, logic exp_play, int exp_locks,
                               int exp_ticks, int got_ticks);
        int errors;
        errors = 0;
        if (display !== exp_board) begin
            $display("Fail t=%0t display exp=%h got=%h", $time, exp_board, display);
            errors++;
        end
        if (lines !== lines_w'(exp_lines)) begin
            $display("Fail t=%0t lines exp=%0d got=%0d", $time, exp_lines, lines);
            errors++;
        end
        if (status.game_over !== exp_go) begin
            $display("Fail t=%0t game_over exp=%b got=%b", $time, exp_go, status.game_over);
            errors++;
        end
        if (status.in_play !== exp_play) begin
            $display("Fail t=%0t in_play exp=%b got=%b", $time, exp_play, status.in_play);
            errors++;
        end
        if (status.piece_locked !== 1'b0) begin
            $display("Fail t=%0t piece_locked exp=0 got=%b", $time, status.piece_locked);
            errors++;
        end
        if (lock_count != exp_locks) begin
            $display("test %0d saw %0d lock pulses where %0d were due, a piece never locked",
                     test, lock_count, exp_locks);
            errors++;
        end
        if (got_ticks != exp_ticks) begin
            $display("test %0d needed %0d ticks before the lock where %0d were due",
                     test, got_ticks, exp_ticks);
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
            $display("test %0d (%s) ok", test, name);
        end else begin
            fail_count++;
            $display("test %0d (%s) failed with %0d errors", test, name, errors);
        end
    endtask

    task automatic report_counts();
        $display("tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
    endtask

endmodule

`default_nettype wire

//--- verif/tb_tetris.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tetris;

    localparam int lines_w     = 8;
    localparam int n_entries   = 14;
    localparam int cycle_limit = 400 * (n_entries + 1);

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    tetris_cfg_pkg::piece_id_t piece_sel;
    tetris_io_pkg::cmd_t       cmd;
    tetris_cfg_pkg::board_t    display;
    logic [lines_w-1:0]        lines;
    tetris_io_pkg::status_t    status;
    int                        cycles = 0;

    // one entry per piece with stimulus and expected values
    tetris_cfg_pkg::piece_id_t tab_piece  [n_entries];
    int                        tab_shift  [n_entries];
    bit                        tab_drop   [n_entries];
    tetris_cfg_pkg::board_t    tab_stored [n_entries];
    tetris_cfg_pkg::board_t    tab_board  [n_entries];
    int                        tab_lines  [n_entries];
    bit                        tab_go     [n_entries];
    int                        tab_locks  [n_entries];
    int                        tab_ticks  [n_entries];

    tetris_core #(
        .lines_w (lines_w)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .piece_sel (piece_sel),
        .cmd       (cmd),
        .display   (display),
        .lines     (lines),
        .status    (status)
    );

    tb_checker #(
        .lines_w (lines_w)
    ) i_checker (
        .clk     (clk),
        .display (display),
        .lines   (lines),
        .status  (status)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("run stopped, DUT made no progress within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // expected boards
    ////////////////////////////////////////////////////////////////////////////

    // mask bit 0 lands on col
    function automatic tetris_cfg_pkg::board_t place(tetris_cfg_pkg::board_t b, int row,
                                                     int col, logic [3:0] mask);
        for (int c = 0; c < 4; c++) begin
            if (mask[c]) begin
                b[row][col+c] = 1'b1;
            end
        end
        return b;
    endfunction

    // a fresh piece at row 0, column 3
    function automatic tetris_cfg_pkg::board_t spawn_view(tetris_cfg_pkg::board_t b,
                                                          tetris_cfg_pkg::piece_id_t id);
        case (id)
            3'd0: b = place(b, 0, 3, 4'b1111);
            3'd1: begin
                b = place(b, 0, 3, 4'b0011);
                b = place(b, 1, 3, 4'b0011);
            end
            default: begin
                b = place(b, 0, 3, 4'b0111);
                b = place(b, 1, 3, 4'b0010);
            end
        endcase
        return b;
    endfunction

    task automatic set_entry(int i, tetris_cfg_pkg::piece_id_t id, int shift, bit drop,
                             tetris_cfg_pkg::board_t st, int nlines, bit go, int locks);
        tab_piece[i]  = id;
        tab_shift[i]  = shift;
        tab_drop[i]   = drop;
        tab_stored[i] = st;
        tab_lines[i]  = nlines;
        tab_go[i]     = go;
        tab_locks[i]  = locks;
        tab_ticks[i]  = 0;
    endtask

    task automatic build_table();
        tetris_cfg_pkg::board_t st;
        int                     top;
        st = '0;
        st = place(st, 19, 0, 4'b1111);
        set_entry(0, 3'd0, -4, 1'b1, st, 0, 1'b0, 1);
        st = place(st, 19, 4, 4'b1111);
        set_entry(1, 3'd0, 1, 1'b1, st, 0, 1'b0, 2);
        // bottom row fills and clears so the O lower half lands on row 19
        st = '0;
        st = place(st, 19, 8, 4'b0011);
        set_entry(2, 3'd1, 6, 1'b1, st, 1, 1'b0, 3);
        st = place(st, 18, 0, 4'b0011);
        st = place(st, 19, 0, 4'b0011);
        set_entry(3, 3'd1, -6, 1'b1, st, 1, 1'b0, 4);
        // T hangs on the O stack at column 1
        st = place(st, 17, 1, 4'b0111);
        st = place(st, 18, 1, 4'b0010);
        set_entry(4, 3'd2, -2, 1'b0, st, 1, 1'b0, 5);
        // 17 ticks bring it down to row 17 and the 18th meets the stack
        tab_ticks[4] = 18;
        for (int k = 0; k < 8; k++) begin
            top = 15 - 2 * k;
            st  = place(st, top, 3, 4'b0011);
            st  = place(st, top + 1, 3, 4'b0011);
            set_entry(5 + k, 3'd1, 0, 1'b1, st, 1, k == 7, 6 + k);
        end
        set_entry(13, 3'd1, -2, 1'b1, st, 1, 1'b1, 13);
        // the next piece already sits at the spawn point when a piece settles
        for (int i = 0; i < n_entries; i++) begin
            tab_board[i] = spawn_view(tab_stored[i],
                                      (i + 1 < n_entries) ? tab_piece[i+1] : tab_piece[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_ready();
        do begin
            @(negedge clk);
        end while (!(status.in_play || status.game_over));
    endtask

    task automatic send_cmd(tetris_io_pkg::cmd_t c);
        @(posedge clk);
        cmd <= c;
        @(posedge clk);
        cmd <= '0;
        wait_ready();
    endtask

    task automatic run_entry(int i);
        tetris_io_pkg::cmd_t c;
        int                  locks_before;
        int                  n;
        @(posedge clk);
        piece_sel <= (i + 1 < n_entries) ? tab_piece[i+1] : tab_piece[i];
        n = 0;
        for (int s = 0; s < ((tab_shift[i] < 0) ? -tab_shift[i] : tab_shift[i]); s++) begin
            c = '0;
            c.move_left  = (tab_shift[i] < 0);
            c.move_right = (tab_shift[i] > 0);
            send_cmd(c);
        end
        c = '0;
        if (tab_drop[i]) begin
            c.hard_drop = 1'b1;
            send_cmd(c);
        end else begin
            c.tick       = 1'b1;
            locks_before = i_checker.lock_count;
            while (i_checker.lock_count == locks_before && n < 25) begin
                send_cmd(c);
                n++;
            end
        end
        i_checker.check_state(i + 2, "piece", tab_board[i], tab_lines[i], tab_go[i],
                              !tab_go[i], tab_locks[i], tab_ticks[i], n);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        cmd       = '0;
        build_table();
        piece_sel = tab_piece[0];
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        i_checker.check_state(0, "reset", '0, 0, 1'b0, 1'b0, 0, 0, 0);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_ready();
        i_checker.check_state(1, "spawn", spawn_view('0, tab_piece[0]), 0, 1'b0, 1'b1, 0,
                              0, 0);
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        i_checker.report_counts();
        if (i_checker.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/tetris_cfg_pkg.sv
hdl/tetris_io_pkg.sv
hdl/collision.sv
hdl/playfield.sv
hdl/game_ctrl.sv
hdl/tetris_core.sv
verif/tb_checker.sv
verif/tb_tetris.sv

//--- Makefile
.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_tetris | tee sim.log
	grep -q "STATUS: PASS" sim.log

build:
	verilator --binary --timing --top-module tb_tetris -f sources.f -o Vtb_tetris

lint:
	verilator --lint-only -Wall --top-module tetris_core \
		hdl/tetris_cfg_pkg.sv hdl/tetris_io_pkg.sv hdl/collision.sv \
		hdl/playfield.sv hdl/game_ctrl.sv hdl/tetris_core.sv

clean:
	rm -rf obj_dir sim.log
